// File: build.f
trace_pkg.sv
stage_tracker.sv
stamp_table.sv
retire_reporter.sv
pipe_trace_top.sv
tb_clock_gen.sv
pipe_trace_tb.sv

// File: pipe_trace_tb.sv
/*
 * Pipeline trace unit testbench
 * Random stall and instruction stimulus against a cycle model of the
 * five-stage pipeline, checking every retire record field by field
 */
`timescale 1ns/10ps

module pipe_trace_tb
    import trace_pkg::*;
;

    // expected retire record for one instruction
    typedef struct packed {
        trace_id_t  id;
        instr_t     instr;
        cycle_t     fetch;
        cycle_t     decode;
        cycle_t     execute;
        cycle_t     mem;
        cycle_t     wb;
        stall_cnt_t stall;
        cycle_t     latency;
    } trace_rec_t;

    logic clk, rst, restart, stall;
    instr_t fetch_instr;
    logic retire_valid;
    trace_id_t retire_id;
    instr_t retire_instr;
    cycle_t retire_fetch_cycle, retire_decode_cycle, retire_execute_cycle;
    cycle_t retire_mem_cycle, retire_wb_cycle, retire_latency;
    stall_cnt_t retire_stall_cycles;

    // model state with one valid and record per stage
    logic f_v, d_v, e_v, m_v, w_v;
    trace_rec_t f_r, d_r, e_r, m_r, w_r;
    cycle_t model_cycle;
    trace_id_t model_next_id;
    trace_rec_t exp_q[$];

    int mismatch_count = 0;
    int fail_count = 0;
    int fetched_count = 0;
    int retired_count = 0;
    int total_retired = 0;
    int stall_run = 0;
    // rst level seen by the model at its last step
    logic in_reset = 1'b0;
    logic aborted = 1'b0;
    logic clean_phase = 1'b0;
    logic have_last = 1'b0;
    logic saw_wrap = 1'b0;
    trace_id_t last_id;

    tb_clock_gen clock_gen (.restart(restart), .clk(clk), .rst(rst));

    pipe_trace_top dut (
        .clk(clk), .rst(rst), .stall(stall), .fetch_instr(fetch_instr),
        .retire_valid(retire_valid), .retire_id(retire_id), .retire_instr(retire_instr),
        .retire_fetch_cycle(retire_fetch_cycle), .retire_decode_cycle(retire_decode_cycle),
        .retire_execute_cycle(retire_execute_cycle), .retire_mem_cycle(retire_mem_cycle),
        .retire_wb_cycle(retire_wb_cycle), .retire_stall_cycles(retire_stall_cycles),
        .retire_latency(retire_latency)
    );

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_id(input string name, input trace_id_t got, input trace_id_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_cycle(input string name, input cycle_t got, input cycle_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_stall(input string name, input stall_cnt_t got, input stall_cnt_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic compare_record(input trace_rec_t exp);
        check_id("retire_id", retire_id, exp.id);
        check_instr("retire_instr", retire_instr, exp.instr);
        check_cycle("retire_fetch_cycle", retire_fetch_cycle, exp.fetch);
        check_cycle("retire_decode_cycle", retire_decode_cycle, exp.decode);
        check_cycle("retire_execute_cycle", retire_execute_cycle, exp.execute);
        check_cycle("retire_mem_cycle", retire_mem_cycle, exp.mem);
        check_cycle("retire_wb_cycle", retire_wb_cycle, exp.wb);
        check_stall("retire_stall_cycles", retire_stall_cycles, exp.stall);
        check_cycle("retire_latency", retire_latency, exp.latency);
        // stall-free stretch has stamps one apart and a fixed latency
        if (clean_phase) begin
            check_stall("retire_stall_cycles", retire_stall_cycles, '0);
            check_cycle("retire_latency", retire_latency, cycle_t'(base_latency));
            check_cycle("retire_decode_cycle", retire_decode_cycle, exp.fetch + 1'b1);
            check_cycle("retire_execute_cycle", retire_execute_cycle, exp.fetch + 2'd2);
            check_cycle("retire_mem_cycle", retire_mem_cycle, exp.fetch + 2'd3);
            check_cycle("retire_wb_cycle", retire_wb_cycle, exp.fetch + 3'd4);
        end
        if (have_last && exp.id == '0 && last_id == trace_id_t'(trace_depth - 1))
            saw_wrap = 1'b1;
        last_id = exp.id;
        have_last = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // pipeline model
    ////////////////////////////////////////////////////////////////////////////

    // predicts the coming rising edge from the inputs it will sample
    task automatic model_step(input logic r, input logic s, input instr_t w);
        if (r) begin
            {f_v, d_v, e_v, m_v, w_v} = '0;
            model_cycle = '0;
            model_next_id = '0;
            // in-flight records die with the reset
            exp_q.delete();
            fetched_count = 0;
            retired_count = 0;
            have_last = 1'b0;
            in_reset = 1'b1;
        end else begin
            in_reset = 1'b0;
            model_cycle = model_cycle + 1'b1;
            // write-back occupant retires one cycle after its write-back cycle
            if (w_v)
                exp_q.push_back(w_r);
            w_v = m_v;
            w_r = m_r;
            w_r.wb = model_cycle;
            w_r.latency = cycle_t'(base_latency + w_r.stall);
            m_v = e_v;
            m_r = e_r;
            m_r.mem = model_cycle;
            if (s) begin
                // bubble into execute, front occupants wait
                e_v = 1'b0;
                if (f_v && f_r.stall != stall_max)
                    f_r.stall = f_r.stall + 1'b1;
                if (d_v && d_r.stall != stall_max)
                    d_r.stall = d_r.stall + 1'b1;
            end else begin
                e_v = d_v;
                e_r = d_r;
                e_r.execute = model_cycle;
                d_v = f_v;
                d_r = f_r;
                d_r.decode = model_cycle;
                f_v = 1'b1;
                f_r = '0;
                f_r.id = model_next_id;
                f_r.instr = w;
                f_r.fetch = model_cycle;
                model_next_id = model_next_id + 1'b1;
                fetched_count++;
            end
        end
    endtask

    // outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        trace_rec_t exp;
        if (in_reset && retire_valid !== 1'b0) begin
            $display("ERROR: retire_valid is not low while rst is held");
            fail_count++;
        end else if (retire_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: retirement of id 0x%h that the model did not expect",
                         retire_id);
                fail_count++;
            end else begin
                exp = exp_q.pop_front();
                compare_record(exp);
                retired_count++;
                total_retired++;
            end
        end else if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            $display("ERROR: expected retirement of id 0x%h did not appear", exp.id);
            fail_count++;
        end
        model_step(rst, stall, fetch_instr);
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(input logic s, input instr_t w);
        @(posedge clk);
        #2;
        stall = s;
        fetch_instr = w;
    endtask

    // about one stall in four and never more than 4 in a row
    task automatic drive_random();
        logic s;
        if (stall_run >= 4)
            s = 1'b0;
        else
            s = ($urandom % 4) == 0;
        stall_run = s ? stall_run + 1 : 0;
        drive_cycle(s, $urandom);
    endtask

    // stall stays low around reset edges
    task automatic wait_rst_level(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (rst !== level && n < limit) begin
            drive_cycle(1'b0, $urandom);
            n++;
        end
        if (rst !== level) begin
            $display("ERROR: timed out waiting for %s", what);
            fail_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_retired(input int target, input int limit);
        int n;
        n = 0;
        while (total_retired < target && n < limit) begin
            drive_random();
            n++;
        end
        if (total_retired < target) begin
            $display("ERROR: only %0d of %0d retirements seen before timeout",
                     total_retired, target);
            fail_count++;
            aborted = 1'b1;
        end
    endtask

    // stall held low until everything fetched so far has retired
    task automatic drain(input int limit);
        int n;
        int target;
        n = 0;
        target = fetched_count;
        while (retired_count < target && n < limit) begin
            drive_cycle(1'b0, $urandom);
            n++;
        end
        if (retired_count != target) begin
            $display("ERROR: drain ended with %0d retired of %0d fetched",
                     retired_count, target);
            fail_count++;
        end
    endtask

    initial begin
        void'($urandom(15));
        stall = 1'b0;
        fetch_instr = '0;
        restart = 1'b0;
        wait_rst_level(1'b0, 100, "rst release after power-up");
        if (!aborted) begin
            clean_phase = 1'b1;
            repeat (40) drive_cycle(1'b0, $urandom);
            clean_phase = 1'b0;
        end
        // long random run that wraps the ids several times
        if (!aborted)
            wait_retired(300, 4000);
        if (!aborted) begin
            restart = 1'b1;
            wait_rst_level(1'b1, 10, "rst to rise on restart");
            restart = 1'b0;
        end
        if (!aborted)
            wait_rst_level(1'b0, 40, "rst release after restart");
        if (!aborted)
            repeat (80) drive_random();
        if (!aborted)
            drain(40);
        if (!aborted && !saw_wrap) begin
            $display("ERROR: retire ids never wrapped from 63 to 0");
            fail_count++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 20 ns clock, reset held for 16 rising edges at power-up and on each restart
 */
`timescale 1ns/10ps

module tb_clock_gen (
    input  logic restart,
    output logic clk,
    output logic rst
);

    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset edges land 2 ns after the clock, like all other stimulus
    initial begin
        rst = 1'b1;
        forever begin
            repeat (reset_cycles) @(posedge clk);
            #2;
            rst = 1'b0;
            @(posedge restart);
            @(posedge clk);
            #2;
            rst = 1'b1;
        end
    end

endmodule

// File: pipe_trace_top.sv
/*
 * Pipeline trace unit
 * Tracker fills the front and back stamp tables and the reporter
 * turns each write-back into one retire record
 */
`timescale 1ns/10ps

module pipe_trace_top
    import trace_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  instr_t     fetch_instr,
    output logic       retire_valid,
    output trace_id_t  retire_id,
    output instr_t     retire_instr,
    output cycle_t     retire_fetch_cycle,
    output cycle_t     retire_decode_cycle,
    output cycle_t     retire_execute_cycle,
    output cycle_t     retire_mem_cycle,
    output cycle_t     retire_wb_cycle,
    output stall_cnt_t retire_stall_cycles,
    output cycle_t     retire_latency
);

    // tracker to tables
    logic         front_wr_en;
    trace_id_t    front_wr_id;
    front_stamp_t front_wr_data;
    logic         back_wr_en;
    trace_id_t    back_wr_id;
    back_stamp_t  back_wr_data;

    // tracker to reporter
    logic         wb_valid;
    trace_id_t    wb_id;
    cycle_t       wb_cycle;

    // reporter and tables
    trace_id_t    rd_id;
    front_stamp_t front_rd_data;
    back_stamp_t  back_rd_data;

    stage_tracker u_tracker (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .fetch_instr   (fetch_instr),
        .front_wr_en   (front_wr_en),
        .front_wr_id   (front_wr_id),
        .front_wr_data (front_wr_data),
        .back_wr_en    (back_wr_en),
        .back_wr_id    (back_wr_id),
        .back_wr_data  (back_wr_data),
        .wb_valid      (wb_valid),
        .wb_id         (wb_id),
        .wb_cycle      (wb_cycle)
    );

    // fetch and decode half of the record
    stamp_table #(.payload_t(front_stamp_t)) front_table (
        .clk     (clk),
        .wr_en   (front_wr_en),
        .wr_id   (front_wr_id),
        .wr_data (front_wr_data),
        .rd_id   (rd_id),
        .rd_data (front_rd_data)
    );

    // execute and memory half of the record
    stamp_table #(.payload_t(back_stamp_t)) back_table (
        .clk     (clk),
        .wr_en   (back_wr_en),
        .wr_id   (back_wr_id),
        .wr_data (back_wr_data),
        .rd_id   (rd_id),
        .rd_data (back_rd_data)
    );

    retire_reporter u_reporter (
        .clk                  (clk),
        .rst                  (rst),
        .wb_valid             (wb_valid),
        .wb_id                (wb_id),
        .wb_cycle             (wb_cycle),
        .front_rd_data        (front_rd_data),
        .back_rd_data         (back_rd_data),
        .rd_id                (rd_id),
        .retire_valid         (retire_valid),
        .retire_id            (retire_id),
        .retire_instr         (retire_instr),
        .retire_fetch_cycle   (retire_fetch_cycle),
        .retire_decode_cycle  (retire_decode_cycle),
        .retire_execute_cycle (retire_execute_cycle),
        .retire_mem_cycle     (retire_mem_cycle),
        .retire_wb_cycle      (retire_wb_cycle),
        .retire_stall_cycles  (retire_stall_cycles),
        .retire_latency       (retire_latency)
    );

endmodule

// File: retire_reporter.sv
/*
 * Retire reporter
 * Reads both stamp tables at the write-back id and emits the full
 * retire record one cycle later along with its fetch to write-back latency
 */
`timescale 1ns/10ps

module retire_reporter
    import trace_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         wb_valid,
    input  trace_id_t    wb_id,
    input  cycle_t       wb_cycle,
    input  front_stamp_t front_rd_data,
    input  back_stamp_t  back_rd_data,
    output trace_id_t    rd_id,
    output logic         retire_valid,
    output trace_id_t    retire_id,
    output instr_t       retire_instr,
    output cycle_t       retire_fetch_cycle,
    output cycle_t       retire_decode_cycle,
    output cycle_t       retire_execute_cycle,
    output cycle_t       retire_mem_cycle,
    output cycle_t       retire_wb_cycle,
    output stall_cnt_t   retire_stall_cycles,
    output cycle_t       retire_latency
);

    // previous retire id for the sequence check
    trace_id_t last_id;
    logic      have_last;

    // table lookup follows write-back directly
    assign rd_id = wb_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            have_last    <= 1'b0;
        end else begin
            retire_valid <= wb_valid;
            if (retire_valid)
                have_last <= 1'b1;
        end
    end

    // id and stamp ride along with the table read
    always_ff @(posedge clk) begin
        retire_id       <= wb_id;
        retire_wb_cycle <= wb_cycle;
        if (retire_valid)
            last_id <= retire_id;
    end

    ////////////////////////////////////////////////////////////////////////////
    // record assembly
    ////////////////////////////////////////////////////////////////////////////

    assign retire_instr         = front_rd_data.instr;
    assign retire_fetch_cycle   = front_rd_data.fetch_cycle;
    assign retire_decode_cycle  = front_rd_data.decode_cycle;
    assign retire_stall_cycles  = front_rd_data.stall_cnt;
    assign retire_execute_cycle = back_rd_data.execute_cycle;
    assign retire_mem_cycle     = back_rd_data.mem_cycle;
    // wraps with the cycle counter
    assign retire_latency       = retire_wb_cycle - retire_fetch_cycle;

    // ids retire in fetch order with no gaps
    a_id_sequence: assert property (@(posedge clk) disable iff (rst)
        retire_valid && have_last |-> retire_id == trace_id_t'(last_id + 1'b1));

    // every extra cycle in flight was a front-end stall
    a_latency: assert property (@(posedge clk) disable iff (rst)
        retire_valid && retire_stall_cycles != stall_max
        |-> retire_latency == cycle_t'(base_latency + retire_stall_cycles));

endmodule

// File: stamp_table.sv
/*
 * Stamp table
 * Id-indexed record store with one write port and a registered read port
 */
`timescale 1ns/10ps

module stamp_table
    import trace_pkg::*;
#(
    // record layout held in each slot
    parameter type payload_t = logic [7:0]
) (
    input  logic      clk,
    input  logic      wr_en,
    input  trace_id_t wr_id,
    input  payload_t  wr_data,
    input  trace_id_t rd_id,
    output payload_t  rd_data
);

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    // one slot per id, reused once ids wrap
    payload_t mem [trace_depth];

    // write port
    // a slot is rewritten only after its previous owner retired
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_id] <= wr_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////////

    // data lands one cycle after rd_id
    // a valid read never targets the slot being written in that cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_id];
    end

endmodule

// File: stage_tracker.sv
/*
 * Stage tracker
 * Runs the cycle counter, walks ids through the five stages under stall
 * and writes the front and back halves of each record into the tables
 */
`timescale 1ns/10ps

module stage_tracker
    import trace_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  instr_t       fetch_instr,
    output logic         front_wr_en,
    output trace_id_t    front_wr_id,
    output front_stamp_t front_wr_data,
    output logic         back_wr_en,
    output trace_id_t    back_wr_id,
    output back_stamp_t  back_wr_data,
    output logic         wb_valid,
    output trace_id_t    wb_id,
    output cycle_t       wb_cycle
);

    cycle_t     cycle_count;
    // stamp for whatever enters a stage at this edge
    cycle_t     cycle_next;
    trace_id_t  next_id;

    // fetch occupant
    logic       f_valid;
    trace_id_t  f_id;
    instr_t     f_instr;
    cycle_t     f_cycle;
    stall_cnt_t f_stall;

    // decode occupant
    logic       d_valid;
    trace_id_t  d_id;
    instr_t     d_instr;
    cycle_t     d_fetch_cycle;
    cycle_t     d_cycle;
    stall_cnt_t d_stall;

    // execute and memory occupants
    logic       e_valid;
    trace_id_t  e_id;
    cycle_t     e_cycle;
    logic       m_valid;
    trace_id_t  m_id;
    cycle_t     m_exec_cycle;
    cycle_t     m_cycle;

    function automatic stall_cnt_t sat_inc(input stall_cnt_t cnt);
        return (cnt == stall_max) ? cnt : stall_cnt_t'(cnt + 1'b1);
    endfunction

    assign cycle_next = cycle_count + 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
            next_id     <= '0;
            f_valid     <= 1'b0;
            d_valid     <= 1'b0;
            e_valid     <= 1'b0;
            m_valid     <= 1'b0;
            wb_valid    <= 1'b0;
        end else begin
            cycle_count <= cycle_next;
            // stall holds fetch and decode and drops a bubble into execute
            e_valid     <= d_valid && !stall;
            m_valid     <= e_valid;
            wb_valid    <= m_valid;
            if (!stall) begin
                f_valid <= 1'b1;
                d_valid <= f_valid;
                next_id <= next_id + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ids and stamps
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (stall) begin
            // occupants held in the front stages pay for the stall
            if (f_valid)
                f_stall <= sat_inc(f_stall);
            if (d_valid)
                d_stall <= sat_inc(d_stall);
        end else begin
            f_id          <= next_id;
            f_instr       <= fetch_instr;
            f_cycle       <= cycle_next;
            f_stall       <= '0;
            d_id          <= f_id;
            d_instr       <= f_instr;
            d_fetch_cycle <= f_cycle;
            d_cycle       <= cycle_next;
            d_stall       <= f_stall;
            e_id          <= d_id;
            e_cycle       <= cycle_next;
        end
        // back stages never stop
        m_id         <= e_id;
        m_exec_cycle <= e_cycle;
        m_cycle      <= cycle_next;
        wb_id        <= m_id;
        wb_cycle     <= cycle_next;
    end

    // last decode cycle is any non-stall cycle with decode valid
    assign front_wr_en   = d_valid && !stall;
    assign front_wr_id   = d_id;
    assign front_wr_data = '{instr: d_instr, fetch_cycle: d_fetch_cycle,
                             decode_cycle: d_cycle, stall_cnt: d_stall};

    // memory lasts exactly one cycle
    assign back_wr_en   = m_valid;
    assign back_wr_id   = m_id;
    assign back_wr_data = '{execute_cycle: m_exec_cycle, mem_cycle: m_cycle};

    // write-back follows the back write of the same id by one cycle
    a_wb_from_mem: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> $past(back_wr_en) && $past(back_wr_id) == wb_id
                     && wb_cycle == cycle_t'($past(back_wr_data.mem_cycle) + 1'b1));

endmodule

// File: trace_pkg.sv
/*
 * Pipeline trace definitions
 * Sizes, stamp types and the two table record layouts shared by the trace unit
 */
package trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    // table slots, ids wrap modulo this
    localparam int trace_depth = 64;
    localparam int id_w        = 6;
    localparam int cycle_w     = 16;
    localparam int stall_w     = 8;

    // cycles from fetch to write-back with no stall
    localparam int base_latency = 4;
    // saturation point of the stall count
    localparam int stall_max    = 2**stall_w - 1;

    typedef logic [id_w-1:0]    trace_id_t;
    typedef logic [cycle_w-1:0] cycle_t;
    typedef logic [stall_w-1:0] stall_cnt_t;
    typedef logic [31:0]        instr_t;

    ////////////////////////////////////////////////////////////////////////////
    // table records
    ////////////////////////////////////////////////////////////////////////////

    // written as the instruction leaves decode, 72 bits
    typedef struct packed {
        instr_t     instr;
        cycle_t     fetch_cycle;
        cycle_t     decode_cycle;
        stall_cnt_t stall_cnt;
    } front_stamp_t;

    // written as the instruction leaves memory, 32 bits
    typedef struct packed {
        cycle_t execute_cycle;
        cycle_t mem_cycle;
    } back_stamp_t;

endpackage
